/* flist.f */
+incdir+src
src/simd_pkg.sv
src/simd_fifo.sv
src/simd_scoreboard.sv
src/simd_alu_pipe.sv
src/simd_divider.sv
src/simd_wb_queue.sv
src/simd_exec_top.sv
sim/simd_exec_chk.sv
sim/simd_exec_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= simd_exec_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# The simulator exits non-zero on any $fatal or failed assertion
run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* sim/simd_exec_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "simd_defs.svh"

module simd_exec_tb;

    import simd_pkg::*;

    localparam int NUM_INSTR   = 33;  // Sum over all directed tests
    localparam int STALL_BURST = `SIMD_ISSUE_DEPTH + `SIMD_RES_DEPTH + `SIMD_RES_CREDITS;

    logic         clk_i = 1'b0;
    logic         rstn_i;
    logic         instr_valid_i;
    simd_instr_t  instr_i;
    logic         instr_credit_o;
    logic         res_credit_i;
    logic         res_valid_o;
    simd_result_t res_o;

    logic [63:0]  rng_state;
    logic [3:0]   next_tag;
    logic         consumer_en;
    simd_result_t exp_res [16];
    int           sent_per_tag [16];
    int           recv_per_tag [16];
    int           sent_count;
    int           credit_returns;  // instr_credit_o pulses seen
    int           res_received;
    int           credits_given;   // res_credit_i pulses driven

    always #10 clk_i = ~clk_i;

    simd_exec_top simd_exec_top_inst (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .instr_valid_i  (instr_valid_i),
        .instr_i        (instr_i),
        .instr_credit_o (instr_credit_o),
        .res_credit_i   (res_credit_i),
        .res_valid_o    (res_valid_o),
        .res_o          (res_o)
    );

    bind simd_exec_top simd_exec_chk simd_exec_chk_inst (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .alu_valid_i    (alu_valid),
        .div_valid_i    (div_valid),
        .instr_valid_i  (instr_valid_i),
        .instr_credit_i (instr_credit_o),
        .res_credit_i   (res_credit_i),
        .res_valid_i    (res_valid_o)
    );

    function automatic logic [63:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 7);
        rng_state = rng_state ^ (rng_state << 17);
        return rng_state;
    endfunction

    // Expected result from the element rules of each operation
    function automatic simd_result_t ref_result(input simd_instr_t ins);
        simd_result_t r;
        int           w;
        logic [63:0]  mask;
        logic [63:0]  a;
        logic [63:0]  b;
        logic [63:0]  sum;
        logic [31:0]  dd;
        logic [31:0]  dv;
        w      = 8 << ins.sew;
        mask   = (w == 64) ? '1 : ((64'd1 << w) - 64'd1);
        r.tag  = ins.tag;
        r.data = '0;
        sum    = '0;
        for (int i = 0; i < 64 / w; i++) begin
            a = (ins.vs1 >> (i * w)) & mask;
            b = (ins.vs2 >> (i * w)) & mask;
            case (ins.op)
                OP_ADD:  r.data = r.data | (((a + b) & mask) << (i * w));
                OP_MUL:  r.data = r.data | (((a * b) & mask) << (i * w));
                default: sum = sum + b;
            endcase
        end
        if (ins.op == OP_REDSUM) r.data = sum & mask;  // Other elements stay zero
        if ((ins.op == OP_DIVU) || (ins.op == OP_REMU)) begin
            for (int l = 0; l < 2; l++) begin
                dd = ins.vs2[l*32 +: 32];
                dv = ins.vs1[l*32 +: 32];
                if (dv == 32'd0)
                    r.data[l*32 +: 32] = (ins.op == OP_DIVU) ? '1 : dd;
                else
                    r.data[l*32 +: 32] = (ins.op == OP_DIVU) ? dd / dv : dd % dv;
            end
        end
        return r;
    endfunction

    task automatic stop_with_failure();
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic report_problem(input string msg);
        $display("%s at %0t", msg, $time);
        stop_with_failure();
    endtask

    task automatic compare_result(input string name, input simd_result_t got,
                                  input simd_result_t exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s got %h expected %h", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic compare_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("ERROR at %0t: %s got %0d expected %0d", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    // Spends one upstream credit, tags are reused only once retired
    task automatic send_instr(input simd_op_t op, input sew_t sew,
                              input logic [63:0] vs1, input logic [63:0] vs2);
        simd_instr_t ins;
        ins.tag = next_tag;
        ins.op  = op;
        ins.sew = sew;
        ins.vs1 = vs1;
        ins.vs2 = vs2;
        while ((sent_count - credit_returns >= `SIMD_ISSUE_DEPTH)
               || (sent_per_tag[next_tag] != recv_per_tag[next_tag])) begin
            @(negedge clk_i);
        end
        exp_res[next_tag]      = ref_result(ins);
        sent_per_tag[next_tag] = sent_per_tag[next_tag] + 1;
        sent_count   <= sent_count + 1;
        instr_i       = ins;
        instr_valid_i = 1'b1;
        next_tag      = next_tag + 4'd1;
        @(negedge clk_i);
        instr_valid_i = 1'b0;
    endtask

    task automatic wait_drain();
        while ((res_received != sent_count) || (credits_given != res_received)) begin
            @(negedge clk_i);
        end
    endtask

    task automatic test_add_mul();
        for (int s = 0; s < 4; s++) begin
            send_instr(OP_ADD, sew_t'(s), next_rand(), next_rand());
            send_instr(OP_MUL, sew_t'(s), next_rand(), next_rand());
        end
        wait_drain();
    endtask

    task automatic test_redsum();
        for (int s = 0; s < 4; s++) send_instr(OP_REDSUM, sew_t'(s), next_rand(), next_rand());
        wait_drain();
    endtask

    task automatic test_divide();
        logic [63:0] dvd;
        logic [63:0] dvs;
        dvd = next_rand();
        dvs = (next_rand() & 64'h0000_0fff_0000_0fff) | 64'h0000_0001_0000_0001;
        send_instr(OP_DIVU, SEW_32, dvs, dvd);
        send_instr(OP_REMU, SEW_32, dvs, dvd);  // Same pair, held remainder
        dvd = next_rand();
        dvs = {32'd0, dvs[31:0]};               // Upper lane divides by zero
        send_instr(OP_DIVU, SEW_32, dvs, dvd);
        send_instr(OP_REMU, SEW_32, dvs, dvd);
        send_instr(OP_DIVU, SEW_32, next_rand() | 64'h0000_0001_0000_0001, next_rand());
        wait_drain();
    endtask

    task automatic test_mixed_burst();
        send_instr(OP_MUL, SEW_64, next_rand(), next_rand());
        send_instr(OP_ADD, SEW_8, next_rand(), next_rand());
        send_instr(OP_REDSUM, SEW_8, next_rand(), next_rand());
        send_instr(OP_DIVU, SEW_32, next_rand() | 64'd1, next_rand());
        send_instr(OP_ADD, SEW_32, next_rand(), next_rand());
        send_instr(OP_MUL, SEW_16, next_rand(), next_rand());
        wait_drain();
    endtask

    task automatic test_backpressure();
        int base_recv;
        consumer_en <= 1'b0;
        base_recv = res_received;
        for (int i = 0; i < STALL_BURST; i++) begin
            send_instr(OP_ADD, SEW_16, next_rand(), next_rand());
        end
        repeat (20) @(negedge clk_i);
        compare_count("res_valid_o count while stalled", res_received - base_recv,
                      `SIMD_RES_CREDITS);
        compare_count("unreturned instructions", sent_count - credit_returns,
                      `SIMD_ISSUE_DEPTH);
        consumer_en <= 1'b1;
        wait_drain();
    endtask

    task automatic test_credit_total();
        repeat (50) @(negedge clk_i);
        compare_count("instr_credit_o pulses", credit_returns, sent_count);
    endtask

    // Outputs come from registers only, so the falling edge sees them settled
    always @(negedge clk_i) begin
        if (rstn_i) begin
            if (instr_credit_o) credit_returns <= credit_returns + 1;
            if (res_valid_o) begin
                if (sent_per_tag[res_o.tag] == recv_per_tag[res_o.tag])
                    report_problem($sformatf("result for tag %0d was not outstanding",
                                             res_o.tag));
                else
                    compare_result($sformatf("res_o tag %0d", res_o.tag), res_o,
                                   exp_res[res_o.tag]);
                recv_per_tag[res_o.tag] <= recv_per_tag[res_o.tag] + 1;
                res_received            <= res_received + 1;
            end
        end
    end

    initial begin : consumer
        res_credit_i = 1'b0;
        forever begin
            @(negedge clk_i);
            if (rstn_i && consumer_en && (credits_given < res_received)) begin
                res_credit_i   = 1'b1;  // One credit back per result taken
                credits_given <= credits_given + 1;
            end else begin
                res_credit_i = 1'b0;
            end
        end
    end

    initial begin : watchdog
        repeat (16 + NUM_INSTR * (`SIMD_DIV_LAT + 20)) @(posedge clk_i);
        report_problem("Watchdog timeout, the tests did not finish");
    end

    initial begin
        rstn_i        = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        next_tag      = '0;
        rng_state     = 64'd98;
        consumer_en  <= 1'b1;
        repeat (16) @(posedge clk_i);
        @(negedge clk_i);
        rstn_i = 1'b1;
        test_add_mul();
        test_redsum();
        test_divide();
        test_mixed_burst();
        test_backpressure();
        test_credit_total();
        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* sim/simd_exec_chk.sv */
`timescale 1ns/1ps
`default_nettype none

`include "simd_defs.svh"

module simd_exec_chk (
    input logic clk_i,
    input logic rstn_i,
    input logic alu_valid_i,
    input logic div_valid_i,
    input logic instr_valid_i,
    input logic instr_credit_i,
    input logic res_credit_i,
    input logic res_valid_i
);

    int push_cnt_q;
    int pop_cnt_q;
    int res_crd_q;   // Consumer credits held by the write-back queue

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            push_cnt_q <= 0;
            pop_cnt_q  <= 0;
            res_crd_q  <= `SIMD_RES_CREDITS;
        end else begin
            push_cnt_q <= push_cnt_q + int'(instr_valid_i);
            pop_cnt_q  <= pop_cnt_q + int'(instr_credit_i);
            res_crd_q  <= res_crd_q + int'(res_credit_i) - int'(res_valid_i);
        end
    end

    // Only one unit owns the write-back port in a cycle
    wb_unique_a: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !(alu_valid_i && div_valid_i))
        else $error("alu and divider results collided on the write-back port");

    // A pop needs an entry pushed in an earlier cycle
    credit_pop_a: assert property (@(posedge clk_i) disable iff (!rstn_i)
        instr_credit_i |-> (pop_cnt_q < push_cnt_q))
        else $error("instr_credit_o pulsed with no matching push");

    res_credit_a: assert property (@(posedge clk_i) disable iff (!rstn_i)
        res_valid_i |-> (res_crd_q > 0))
        else $error("res_valid_o raised with no consumer credit");

endmodule

`default_nettype wire

/* src/simd_exec_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "simd_defs.svh"

module simd_exec_top (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  logic                   instr_valid_i,
    input  simd_pkg::simd_instr_t  instr_i,
    output logic                   instr_credit_o,
    input  logic                   res_credit_i,
    output logic                   res_valid_o,
    output simd_pkg::simd_result_t res_o
);

    import simd_pkg::*;

    logic         head_valid;
    simd_instr_t  head;
    simd_issue_t  issue;
    logic         alu_valid;
    simd_result_t alu_res;
    logic         div_valid;
    simd_result_t div_res;
    logic         res_pop;

    // Each pop frees one upstream credit
    simd_fifo #(
        .T     (simd_instr_t),
        .DEPTH (`SIMD_ISSUE_DEPTH)
    ) issue_fifo_inst (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .push_i  (instr_valid_i),
        .data_i  (instr_i),
        .pop_i   (instr_credit_o),
        .valid_o (head_valid),
        .data_o  (head),
        .empty_o ()
    );

    simd_scoreboard scoreboard_inst (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .head_valid_i (head_valid),
        .head_i       (head),
        .res_pop_i    (res_pop),
        .pop_o        (instr_credit_o),
        .issue_o      (issue)
    );

    simd_alu_pipe alu_pipe_inst (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .issue_i  (issue),
        .valid_o  (alu_valid),
        .result_o (alu_res)
    );

    simd_divider divider_inst (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .issue_i  (issue),
        .valid_o  (div_valid),
        .result_o (div_res)
    );

    simd_wb_queue wb_queue_inst (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .alu_valid_i  (alu_valid),
        .alu_res_i    (alu_res),
        .div_valid_i  (div_valid),
        .div_res_i    (div_res),
        .res_credit_i (res_credit_i),
        .res_valid_o  (res_valid_o),
        .res_o        (res_o),
        .res_pop_o    (res_pop)
    );

endmodule

`default_nettype wire

/* src/simd_wb_queue.sv */
`timescale 1ns/1ps
`default_nettype none

`include "simd_defs.svh"

module simd_wb_queue (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  logic                   alu_valid_i,
    input  simd_pkg::simd_result_t alu_res_i,
    input  logic                   div_valid_i,
    input  simd_pkg::simd_result_t div_res_i,
    input  logic                   res_credit_i,
    output logic                   res_valid_o,
    output simd_pkg::simd_result_t res_o,
    output logic                   res_pop_o
);

    import simd_pkg::*;

    localparam int CRD_W = $clog2(`SIMD_RES_CREDITS + 1);

    logic             push;
    simd_result_t     push_res;
    logic             empty;
    logic [CRD_W-1:0] credit_q;
    logic             send;

    // At most one source is valid per cycle by scheduling
    assign push     = alu_valid_i | div_valid_i;
    assign push_res = alu_valid_i ? alu_res_i : div_res_i;

    simd_fifo #(
        .T     (simd_result_t),
        .DEPTH (`SIMD_RES_DEPTH)
    ) res_fifo_inst (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .push_i  (push),
        .data_i  (push_res),
        .pop_i   (send),
        .valid_o (),
        .data_o  (res_o),
        .empty_o (empty)
    );

    assign send        = !empty && (credit_q != '0);
    assign res_valid_o = send;
    assign res_pop_o   = send;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) credit_q <= CRD_W'(`SIMD_RES_CREDITS);
        else         credit_q <= credit_q + CRD_W'(res_credit_i) - CRD_W'(send);
    end

endmodule

`default_nettype wire

/* src/simd_divider.sv */
`timescale 1ns/1ps
`default_nettype none

`include "simd_defs.svh"

module simd_divider (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  simd_pkg::simd_issue_t  issue_i,
    output logic                   valid_o,
    output simd_pkg::simd_result_t result_o
);

    import simd_pkg::*;

    logic                   busy_q;
    stage_cnt_t             cnt_q;       // Quotient bits produced so far
    logic                   reuse_q;
    simd_op_t               op_q;
    logic [`SIMD_TAG_W-1:0] tag_q;
    logic [31:0]            quo_q [2];   // Dividend shifts out as quotient shifts in
    logic [31:0]            rem_q [2];
    logic [31:0]            dvsr_q [2];

    logic take;
    logic start;
    logic done;

    // One restoring step, returns {remainder, quotient}
    function automatic logic [63:0] div_step(input logic [31:0] r, input logic [31:0] q,
                                             input logic [31:0] d);
        logic [32:0] rs;
        rs = {r, q[31]};
        if (rs >= {1'b0, d}) return {rs[31:0] - d, q[30:0], 1'b1};
        return {rs[31:0], q[30:0], 1'b0};
    endfunction

    assign take  = issue_i.valid
                && ((issue_i.instr.op == OP_DIVU) || (issue_i.instr.op == OP_REMU));
    assign start = take && !issue_i.div_reuse;
    assign done  = busy_q && (cnt_q == stage_cnt_t'(`SIMD_DIV_LAT));

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            busy_q  <= 1'b0;
            cnt_q   <= '0;
            reuse_q <= 1'b0;
        end else begin
            reuse_q <= take && issue_i.div_reuse;
            if (start) begin
                busy_q <= 1'b1;
                cnt_q  <= 6'd1;  // First bit is taken on the issue edge
            end else if (done) begin
                busy_q <= 1'b0;
            end else if (busy_q) begin
                cnt_q <= cnt_q + 6'd1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (take) begin
            op_q  <= issue_i.instr.op;
            tag_q <= issue_i.instr.tag;
        end
        for (int l = 0; l < 2; l++) begin
            if (start) begin
                dvsr_q[l] <= issue_i.instr.vs1[l*32 +: 32];
                {rem_q[l], quo_q[l]} <= div_step(32'd0, issue_i.instr.vs2[l*32 +: 32],
                                                 issue_i.instr.vs1[l*32 +: 32]);
            end else if (busy_q && !done) begin
                {rem_q[l], quo_q[l]} <= div_step(rem_q[l], quo_q[l], dvsr_q[l]);
            end
        end
    end

    // Zero divisor falls out of the recurrence as all-ones and the dividend
    assign valid_o       = done | reuse_q;
    assign result_o.tag  = tag_q;
    assign result_o.data = (op_q == OP_DIVU) ? {quo_q[1], quo_q[0]} : {rem_q[1], rem_q[0]};

endmodule

`default_nettype wire

/* src/simd_alu_pipe.sv */
`timescale 1ns/1ps
`default_nettype none

`include "simd_defs.svh"

module simd_alu_pipe (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  simd_pkg::simd_issue_t  issue_i,
    output logic                   valid_o,
    output simd_pkg::simd_result_t result_o
);

    import simd_pkg::*;

    localparam int IDX_W = $clog2(`SIMD_ALU_SLOTS);

    logic [3:0][`SIMD_VLEN-1:0] add_v;  // One entry per SEW
    logic [3:0][`SIMD_VLEN-1:0] mul_v;
    logic [3:0][`SIMD_VLEN-1:0] red_v;
    logic [`SIMD_VLEN-1:0]      calc;
    logic                       take;
    logic [IDX_W-1:0]           wr_idx;
    logic                       slot_v [`SIMD_ALU_SLOTS];
    simd_result_t               slot_d [`SIMD_ALU_SLOTS];

    for (genvar g = 0; g < 4; g++) begin : g_sew
        localparam int W = 8 << g;
        logic [`SIMD_VLEN-1:0] add_r;
        logic [`SIMD_VLEN-1:0] mul_r;
        logic [W-1:0]          acc;
        always_comb begin
            acc = '0;
            for (int i = 0; i < `SIMD_VLEN / W; i++) begin
                add_r[i*W +: W] = issue_i.instr.vs1[i*W +: W] + issue_i.instr.vs2[i*W +: W];
                mul_r[i*W +: W] = issue_i.instr.vs1[i*W +: W] * issue_i.instr.vs2[i*W +: W];
                acc = acc + issue_i.instr.vs2[i*W +: W];
            end
        end
        assign add_v[g] = add_r;
        assign mul_v[g] = mul_r;
        assign red_v[g] = `SIMD_VLEN'(acc);  // Upper elements stay zero
    end

    always_comb begin
        case (issue_i.instr.op)
            OP_ADD:    calc = add_v[issue_i.instr.sew];
            OP_MUL:    calc = mul_v[issue_i.instr.sew];
            OP_REDSUM: calc = red_v[issue_i.instr.sew];
            default:   calc = '0;
        endcase
    end

    assign take   = issue_i.valid && (issue_i.instr.op != OP_DIVU)
                 && (issue_i.instr.op != OP_REMU);
    assign wr_idx = IDX_W'(issue_i.stages - 6'd1);

    // Slots drain toward 0, a new entry lands stages-1 away from the output
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < `SIMD_ALU_SLOTS; i++) slot_v[i] <= 1'b0;
        end else begin
            for (int i = 0; i < `SIMD_ALU_SLOTS - 1; i++) slot_v[i] <= slot_v[i+1];
            slot_v[`SIMD_ALU_SLOTS-1] <= 1'b0;
            if (take) slot_v[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        for (int i = 0; i < `SIMD_ALU_SLOTS - 1; i++) slot_d[i] <= slot_d[i+1];
        if (take) begin
            slot_d[wr_idx].tag  <= issue_i.instr.tag;
            slot_d[wr_idx].data <= calc;
        end
    end

    assign valid_o  = slot_v[0];
    assign result_o = slot_d[0];

endmodule

`default_nettype wire

/* src/simd_scoreboard.sv */
`timescale 1ns/1ps
`default_nettype none

`include "simd_defs.svh"

module simd_scoreboard (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic                  head_valid_i,
    input  simd_pkg::simd_instr_t head_i,
    input  logic                  res_pop_i,
    output logic                  pop_o,
    output simd_pkg::simd_issue_t issue_o
);

    import simd_pkg::*;

    localparam int RES_W = $clog2(`SIMD_RES_DEPTH + 1);

    // Bit i set means the write-back port is taken i+1 cycles from now
    logic [31:0]           wb_occ_q;
    logic [31:0]           wb_occ_d;
    stage_cnt_t            div_cnt_q;   // Cycles left on the running division
    logic                  held_valid_q;
    logic [`SIMD_VLEN-1:0] held_vs1_q;
    logic [`SIMD_VLEN-1:0] held_vs2_q;
    logic [RES_W-1:0]      res_cnt_q;

    stage_cnt_t stages;
    logic       is_div;
    logic       div_reuse;
    logic       div_start;
    logic       slot_busy;
    logic       div_block;
    logic       res_full;
    logic       issue;

    assign is_div = (head_i.op == OP_DIVU) || (head_i.op == OP_REMU);

    // Held pair is only usable once the divider has settled
    assign div_reuse = is_div && held_valid_q && (div_cnt_q == '0)
                    && (head_i.vs1 == held_vs1_q) && (head_i.vs2 == held_vs2_q);

    always_comb begin
        case (head_i.op)
            OP_MUL:    stages = (head_i.sew == SEW_64) ? 6'd3 : 6'd2;
            OP_REDSUM: begin
                case (head_i.sew)
                    SEW_8, SEW_16: stages = 6'd4;
                    SEW_32:        stages = 6'd3;
                    default:       stages = 6'd2;
                endcase
            end
            OP_DIVU, OP_REMU: stages = div_reuse ? 6'd1 : stage_cnt_t'(`SIMD_DIV_LAT);
            default:   stages = 6'd1;
        endcase
    end

    assign slot_busy = wb_occ_q[5'(stages - 6'd1)];
    assign div_block = is_div && !div_reuse && (div_cnt_q != '0);  // One iterative divider
    assign res_full  = (res_cnt_q == RES_W'(`SIMD_RES_DEPTH));
    assign issue     = head_valid_i && !slot_busy && !div_block && !res_full;
    assign div_start = issue && is_div && !div_reuse;
    assign pop_o     = issue;

    always_comb begin
        issue_o.valid     = issue;
        issue_o.instr     = head_i;
        issue_o.stages    = stages;
        issue_o.div_reuse = div_reuse;
    end

    always_comb begin
        wb_occ_d = wb_occ_q >> 1;
        if (issue && (stages > 6'd1)) wb_occ_d[5'(stages - 6'd2)] = 1'b1;
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            wb_occ_q     <= '0;
            div_cnt_q    <= '0;
            held_valid_q <= 1'b0;
            res_cnt_q    <= '0;
        end else begin
            wb_occ_q <= wb_occ_d;
            if (div_start) begin
                div_cnt_q    <= stage_cnt_t'(`SIMD_DIV_LAT - 1);
                held_valid_q <= 1'b1;
            end else if (div_cnt_q != '0) begin
                div_cnt_q <= div_cnt_q - 6'd1;
            end
            res_cnt_q <= res_cnt_q + RES_W'(issue) - RES_W'(res_pop_i);
        end
    end

    always_ff @(posedge clk_i) begin
        if (div_start) begin
            held_vs1_q <= head_i.vs1;
            held_vs2_q <= head_i.vs2;
        end
    end

endmodule

`default_nettype wire

/* src/simd_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module simd_fifo #(
    parameter type T     = logic,
    parameter int  DEPTH = 4
) (
    input  logic clk_i,
    input  logic rstn_i,
    input  logic push_i,
    input  T     data_i,
    input  logic pop_i,
    output logic valid_o,
    output T     data_o,
    output logic empty_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    T                 mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             do_pop;

    // Wraps at DEPTH so non power-of-two depths also work
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign valid_o = (count_q != '0);
    assign empty_o = ~valid_o;
    assign data_o  = mem[rd_ptr_q];
    assign do_pop  = pop_i & valid_o;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) wr_ptr_q <= next_ptr(wr_ptr_q);
            if (do_pop) rd_ptr_q <= next_ptr(rd_ptr_q);
            count_q <= count_q + CNT_W'(push_i) - CNT_W'(do_pop);
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_i) mem[wr_ptr_q] <= data_i;
    end

endmodule

`default_nettype wire

/* src/simd_pkg.sv */
`default_nettype none

`include "simd_defs.svh"

package simd_pkg;

    typedef enum logic [1:0] {
        SEW_8,
        SEW_16,
        SEW_32,
        SEW_64
    } sew_t;

    typedef enum logic [2:0] {
        OP_ADD,
        OP_MUL,
        OP_REDSUM,
        OP_DIVU,
        OP_REMU
    } simd_op_t;

    typedef logic [5:0] stage_cnt_t;

    typedef struct packed {
        logic [`SIMD_TAG_W-1:0] tag;
        simd_op_t               op;
        sew_t                   sew;
        logic [`SIMD_VLEN-1:0]  vs1;
        logic [`SIMD_VLEN-1:0]  vs2;
    } simd_instr_t;

    typedef struct packed {
        logic [`SIMD_TAG_W-1:0] tag;
        logic [`SIMD_VLEN-1:0]  data;
    } simd_result_t;

    // Issued instruction as seen by both execution units
    typedef struct packed {
        logic        valid;
        simd_instr_t instr;
        stage_cnt_t  stages;
        logic        div_reuse;  // Answer comes from the divider's held pair
    } simd_issue_t;

endpackage

`default_nettype wire

/* src/simd_defs.svh */
`ifndef SIMD_DEFS_SVH
`define SIMD_DEFS_SVH

// Datapath sizes
`define SIMD_VLEN         64
`define SIMD_TAG_W        4

// Queue depths and starting credits
`define SIMD_ISSUE_DEPTH  4
`define SIMD_RES_DEPTH    4
`define SIMD_RES_CREDITS  2

`define SIMD_DIV_LAT      32  // Full-length unsigned division
`define SIMD_ALU_SLOTS    4   // Longest ALU latency is 4 stages

`endif
